/* common/mem_pkg.sv */
// Memory interface package with bus and SRAM widths and the split of a word into two bytes
package mem_pkg;

	// ====================
	// Processor bus
	// ====================

	// Word address and word width on the 12-bit processor bus
	localparam int bus_adr_w = 24;
	localparam int bus_dat_w = 12;

	// ====================
	// External SRAM
	// ====================

	// Byte address and data width of the asynchronous SRAM
	localparam int ram_adr_w = 19;
	localparam int ram_dat_w = 8;

	// Word address bits that reach the SRAM, the lowest byte address bit picks the half
	localparam int ram_word_w = ram_adr_w - 1;

	// Each byte holds six bits of a word, the two bits above them are written as zero
	localparam int half_w = 6;
	localparam int pad_w = ram_dat_w - half_w;

	// Even byte carries the low half of the word
	function automatic logic [ram_dat_w-1:0] lo_byte(input logic [bus_dat_w-1:0] dat);
		return {{pad_w{1'b0}}, dat[half_w-1:0]};
	endfunction

	// Odd byte carries the high half of the word
	function automatic logic [ram_dat_w-1:0] hi_byte(input logic [bus_dat_w-1:0] dat);
		return {{pad_w{1'b0}}, dat[bus_dat_w-1:half_w]};
	endfunction

endpackage

/* common/cache_pkg.sv */
// Read cache geometry package with line size, index and tag fields of a word address
package cache_pkg;

	// ====================
	// Line geometry
	// ====================

	// Sixteen words per line, so four word offset bits
	localparam int word_off_w = 4;
	localparam int line_words = 2 ** word_off_w;

	// Two SRAM bytes per word, so a line is 32 bytes and needs five offset bits
	localparam int byte_off_w = word_off_w + 1;
	localparam int line_bytes = 2 * line_words;

	// ====================
	// Index and tag
	// ====================

	// Direct mapped with 128 lines, index from word address bits 10 to 4
	localparam int index_w = 7;
	localparam int line_count = 2 ** index_w;

	// The tag starts at the same bit as the index and so also holds the index
	localparam int tag_w = mem_pkg::bus_adr_w - word_off_w;

	// Line index of a word address
	function automatic logic [index_w-1:0] get_index(input logic [mem_pkg::bus_adr_w-1:0] adr);
		return adr[word_off_w +: index_w];
	endfunction

	// Tag of a word address, bits 23 to 4
	function automatic logic [tag_w-1:0] get_tag(input logic [mem_pkg::bus_adr_w-1:0] adr);
		return adr[word_off_w +: tag_w];
	endfunction

endpackage

/* sram_seq/sram_sequencer.sv */
// SRAM sequencer that runs two-byte write cycles and 32-byte cache line fills
`timescale 1ns/100ps

module sram_sequencer #(
	parameter int WR_PULSE = 2
)(
	input  logic                          wclk,
	input  logic                          rst,
	input  logic                          req_i,
	input  logic                          we_i,
	input  logic [mem_pkg::bus_adr_w-1:0] adr_i,
	input  logic [mem_pkg::bus_dat_w-1:0] dat_i,
	input  logic                          hit_i,
	output logic                          ram_ce_n_o,
	output logic                          ram_we_n_o,
	output logic                          ram_oe_n_o,
	output logic [mem_pkg::ram_adr_w-1:0] ram_adr_o,
	output logic [mem_pkg::ram_dat_w-1:0] ram_dat_o,
	input  logic [mem_pkg::ram_dat_w-1:0] ram_dat_i,
	output logic                          cache_wr_o,
	output logic [mem_pkg::ram_adr_w-1:0] cache_wa_o,
	output logic [mem_pkg::half_w-1:0]    cache_wd_o,
	output logic                          cache_inv_o,
	output logic                          wr_done_o
);

	// Width of the write strobe counter, at least one bit
	localparam int cnt_w = (WR_PULSE > 1) ? $clog2(WR_PULSE) : 1;

	typedef enum logic [3:0] {
		st_idle,
		st_rd_chk,
		st_rd_adr,
		st_rd_cap,
		st_rd_step,
		st_wr_setup,
		st_wr_pulse,
		st_wr_hold,
		st_wait
	} state_t;

	state_t                          state;
	logic [cnt_w-1:0]                pulse_cnt;
	logic                            odd_byte;
	// One-hot ring, the top bit marks the last byte of the line
	logic [cache_pkg::line_bytes-1:0] ring;

	// The cache is written at the byte address on the pins with the byte the SRAM returns
	assign cache_wa_o = ram_adr_o;
	assign cache_wd_o = ram_dat_i[mem_pkg::half_w-1:0];

	always_ff @(posedge wclk)
	begin
		if (rst)
		begin
			state       <= st_idle;
			ram_ce_n_o  <= 1'b1;
			ram_we_n_o  <= 1'b1;
			ram_oe_n_o  <= 1'b1;
			cache_wr_o  <= 1'b0;
			cache_inv_o <= 1'b0;
			wr_done_o   <= 1'b0;
			odd_byte    <= 1'b0;
			ring        <= cache_pkg::line_bytes'(1);
		end
		else
		begin
			// Cache write and invalidate are single-cycle pulses
			cache_wr_o  <= 1'b0;
			cache_inv_o <= 1'b0;
			case (state)
			// ====================
			// Request decode
			// ====================
			st_idle:
			begin
				if (req_i && we_i)
				begin
					// Even byte first, the cached copy of the word is dropped at once
					ram_adr_o   <= {adr_i[mem_pkg::ram_word_w-1:0], 1'b0};
					ram_dat_o   <= mem_pkg::lo_byte(dat_i);
					ram_ce_n_o  <= 1'b0;
					cache_inv_o <= 1'b1;
					odd_byte    <= 1'b0;
					state       <= st_wr_setup;
				end
				else if (req_i)
					// Hit is registered, so it only reflects this address one cycle on
					state <= st_rd_chk;
			end
			st_rd_chk:
			begin
				if (!req_i)
					state <= st_idle;
				else if (hit_i)
					state <= st_wait;
				else
				begin
					// Miss, so start the fill at byte zero of the line
					ram_adr_o  <= {adr_i[mem_pkg::ram_word_w-1:cache_pkg::word_off_w],
						cache_pkg::byte_off_w'(0)};
					ram_ce_n_o <= 1'b0;
					ram_oe_n_o <= 1'b0;
					ring       <= cache_pkg::line_bytes'(1);
					state      <= st_rd_adr;
				end
			end
			// ====================
			// Line fill
			// ====================
			st_rd_adr:
			begin
				// Address is stable on the pins, capture the byte next cycle
				cache_wr_o <= 1'b1;
				state      <= st_rd_cap;
			end
			st_rd_cap:
			begin
				// Byte is written into the cache in this cycle
				if (ring[cache_pkg::line_bytes-1] || hit_i)
				begin
					ram_ce_n_o <= 1'b1;
					ram_oe_n_o <= 1'b1;
					state      <= st_wait;
				end
				else
					state <= st_rd_step;
			end
			st_rd_step:
			begin
				ram_adr_o[cache_pkg::byte_off_w-1:0] <=
					ram_adr_o[cache_pkg::byte_off_w-1:0] + cache_pkg::byte_off_w'(1);
				ring <= {ring[cache_pkg::line_bytes-2:0], ring[cache_pkg::line_bytes-1]};
				if (hit_i)
				begin
					ram_ce_n_o <= 1'b1;
					ram_oe_n_o <= 1'b1;
					state      <= st_wait;
				end
				else
					state <= st_rd_adr;
			end
			// ====================
			// Byte write
			// ====================
			st_wr_setup:
			begin
				// Address and data have had a cycle to settle before the strobe
				ram_we_n_o <= 1'b0;
				pulse_cnt  <= cnt_w'(WR_PULSE - 1);
				state      <= st_wr_pulse;
			end
			st_wr_pulse:
			begin
				if (pulse_cnt == '0)
				begin
					ram_we_n_o <= 1'b1;
					state      <= st_wr_hold;
				end
				else
					pulse_cnt <= pulse_cnt - cnt_w'(1);
			end
			st_wr_hold:
			begin
				// Address and data stay put for one cycle after the strobe rises
				if (!odd_byte)
				begin
					ram_adr_o[0] <= 1'b1;
					ram_dat_o    <= mem_pkg::hi_byte(dat_i);
					odd_byte     <= 1'b1;
					state        <= st_wr_setup;
				end
				else
				begin
					ram_ce_n_o <= 1'b1;
					wr_done_o  <= 1'b1;
					state      <= st_wait;
				end
			end
			// Hold here until the master drops its request
			st_wait:
			begin
				if (!req_i)
				begin
					wr_done_o <= 1'b0;
					state     <= st_idle;
				end
			end
			default:
				state <= st_idle;
			endcase
		end
	end

endmodule

/* read_cache/read_cache.sv */
// Direct-mapped read cache with byte-half fill, tag store, valid bits and invalidate
`timescale 1ns/100ps

module read_cache (
	input  logic                          wclk,
	input  logic                          rst,
	input  logic                          wr_i,
	input  logic [mem_pkg::ram_adr_w-1:0] wa_i,
	input  logic [mem_pkg::half_w-1:0]    wd_i,
	input  logic [mem_pkg::bus_adr_w-1:0] ra_i,
	output logic [mem_pkg::bus_dat_w-1:0] rd_o,
	output logic                          hit_o,
	input  logic                          inv_i
);

	// Word address bits that select a cached word, index plus word offset
	localparam int word_adr_w = cache_pkg::index_w + cache_pkg::word_off_w;
	localparam int cache_words = cache_pkg::line_count * cache_pkg::line_words;

	// ====================
	// Storage
	// ====================

	logic [mem_pkg::bus_dat_w-1:0] data_mem [0:cache_words-1];
	logic [cache_pkg::tag_w-1:0]   tag_mem [0:cache_pkg::line_count-1];
	logic [cache_pkg::line_count-1:0] valid;

	logic [word_adr_w-1:0]         fill_word;
	logic [cache_pkg::index_w-1:0] fill_line;
	logic                          fill_last;
	logic [cache_pkg::index_w-1:0] req_line;
	logic [cache_pkg::tag_w-1:0]   req_tag;
	logic                          tag_match;

	// Byte address bit 0 picks the half, the bits above it give the word
	assign fill_word = wa_i[1 +: word_adr_w];
	assign fill_line = wa_i[cache_pkg::byte_off_w +: cache_pkg::index_w];
	assign fill_last = wr_i && (wa_i[cache_pkg::byte_off_w-1:0] == '1);

	// Index and tag of the address the bus is presenting
	assign req_line  = cache_pkg::get_index(ra_i);
	assign req_tag   = cache_pkg::get_tag(ra_i);
	assign tag_match = (tag_mem[req_line] == req_tag);

	// ====================
	// Fill
	// ====================

	// Even bytes land in the low half of the word and odd bytes in the high half
	always_ff @(posedge wclk)
	begin
		if (wr_i)
		begin
			if (wa_i[0])
				data_mem[fill_word][mem_pkg::bus_dat_w-1:mem_pkg::half_w] <= wd_i;
			else
				data_mem[fill_word][mem_pkg::half_w-1:0] <= wd_i;
		end
	end

	// The bus request is held through the fill, so its address carries the full tag
	always_ff @(posedge wclk)
	begin
		if (fill_last)
			tag_mem[fill_line] <= req_tag;
	end

	// A line turns valid with its last byte and is dropped when a write hits its tag
	always_ff @(posedge wclk)
	begin
		if (rst)
			valid <= '0;
		else if (inv_i && tag_match)
			valid[req_line] <= 1'b0;
		else if (fill_last)
			valid[fill_line] <= 1'b1;
	end

	// ====================
	// Lookup
	// ====================

	// Data and hit both come out one cycle after the address
	always_ff @(posedge wclk)
	begin
		rd_o <= data_mem[ra_i[word_adr_w-1:0]];
	end

	always_ff @(posedge wclk)
	begin
		if (rst)
			hit_o <= 1'b0;
		else
			hit_o <= valid[req_line] && tag_match;
	end

endmodule

/* design/bus_ack_gen.sv */
// Bus acknowledge stage with a delay chain for read hits and a stage for finished writes
`timescale 1ns/100ps

module bus_ack_gen #(
	parameter int READ_STAGES = 2
)(
	input  logic wclk,
	input  logic rst,
	input  logic rd_req_i,
	input  logic wr_done_i,
	input  logic stb_i,
	output logic ack_o
);

	// The ack register is the last read stage, the chain holds the ones before it
	localparam int pipe_w = (READ_STAGES > 1) ? READ_STAGES - 1 : 1;

	logic [pipe_w-1:0] rd_pipe;
	logic              rd_tap;

	// With a single stage the read request feeds the ack register directly
	assign rd_tap = (READ_STAGES > 1) ? rd_pipe[pipe_w-1] : rd_req_i;

	// ====================
	// Read delay chain
	// ====================

	// The chain empties as soon as the strobe drops so no stale ack survives
	always_ff @(posedge wclk)
	begin
		if (rst)
			rd_pipe <= '0;
		else if (stb_i)
			rd_pipe <= (rd_pipe << 1) | pipe_w'(rd_req_i);
		else
			rd_pipe <= '0;
	end

	// ====================
	// Acknowledge
	// ====================

	// Write completion takes this single stage, so ack follows wr_done by one cycle
	// The ack falls in the cycle after the strobe goes low
	always_ff @(posedge wclk)
	begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= stb_i && (rd_tap || wr_done_i);
	end

endmodule

/* design/mem12_top.sv */
// Top level of mem12 joining the SRAM sequencer, read cache and acknowledge stage
`timescale 1ns/100ps

module mem12_top #(
	parameter int WR_PULSE    = 2,
	parameter int READ_STAGES = 2
)(
	input  logic                          wclk,
	input  logic                          rst,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [mem_pkg::bus_adr_w-1:0] adr_i,
	input  logic [mem_pkg::bus_dat_w-1:0] dat_i,
	output logic [mem_pkg::bus_dat_w-1:0] dat_o,
	output logic                          ack_o,
	output logic                          ram_ce_n_o,
	output logic                          ram_we_n_o,
	output logic                          ram_oe_n_o,
	output logic [mem_pkg::ram_adr_w-1:0] ram_adr_o,
	output logic [mem_pkg::ram_dat_w-1:0] ram_dat_o,
	input  logic [mem_pkg::ram_dat_w-1:0] ram_dat_i
);

	logic                          req;
	logic                          req_q;
	logic                          hit;
	logic                          cache_wr;
	logic [mem_pkg::ram_adr_w-1:0] cache_wa;
	logic [mem_pkg::half_w-1:0]    cache_wd;
	logic                          cache_inv;
	logic [mem_pkg::bus_dat_w-1:0] cache_rd;
	logic                          wr_done;

	// Cycle and strobe together select the memory
	assign req = cyc_i & stb_i;

	// Hit is registered against the bus address, so it still belongs to the
	// previous request in the first cycle of a new one
	always_ff @(posedge wclk)
	begin
		if (rst)
			req_q <= 1'b0;
		else
			req_q <= req;
	end

	// ====================
	// Request pipeline
	// ====================

	sram_sequencer #(
		.WR_PULSE(WR_PULSE)
	) u_seq (
		.wclk        (wclk),
		.rst         (rst),
		.req_i       (req),
		.we_i        (we_i),
		.adr_i       (adr_i),
		.dat_i       (dat_i),
		.hit_i       (hit),
		.ram_ce_n_o  (ram_ce_n_o),
		.ram_we_n_o  (ram_we_n_o),
		.ram_oe_n_o  (ram_oe_n_o),
		.ram_adr_o   (ram_adr_o),
		.ram_dat_o   (ram_dat_o),
		.ram_dat_i   (ram_dat_i),
		.cache_wr_o  (cache_wr),
		.cache_wa_o  (cache_wa),
		.cache_wd_o  (cache_wd),
		.cache_inv_o (cache_inv),
		.wr_done_o   (wr_done)
	);

	read_cache u_cache (
		.wclk  (wclk),
		.rst   (rst),
		.wr_i  (cache_wr),
		.wa_i  (cache_wa),
		.wd_i  (cache_wd),
		.ra_i  (adr_i),
		.rd_o  (cache_rd),
		.hit_o (hit),
		.inv_i (cache_inv)
	);

	// Only a read that hits starts the read acknowledge chain
	bus_ack_gen #(
		.READ_STAGES(READ_STAGES)
	) u_ack (
		.wclk      (wclk),
		.rst       (rst),
		.rd_req_i  (req & req_q & ~we_i & hit),
		.wr_done_i (wr_done),
		.stb_i     (req),
		.ack_o     (ack_o)
	);

	// Read data follows the cache while selected and is zero otherwise
	always_ff @(posedge wclk)
	begin
		if (req)
			dat_o <= cache_rd;
		else
			dat_o <= '0;
	end

endmodule

/* tb/sram_model.sv */
// Behavioural asynchronous SRAM with an 8-bit data path, driven by the mem12 pins
`timescale 1ns/100ps

module sram_model (
	input  logic                          ce_n_i,
	input  logic                          we_n_i,
	input  logic                          oe_n_i,
	input  logic [mem_pkg::ram_adr_w-1:0] adr_i,
	input  logic [mem_pkg::ram_dat_w-1:0] dat_i,
	output logic [mem_pkg::ram_dat_w-1:0] dat_o
);

	// Every byte address of the device has a location
	localparam int depth = 2 ** mem_pkg::ram_adr_w;

	logic [mem_pkg::ram_dat_w-1:0] mem [0:depth-1];

	// ====================
	// Contents
	// ====================

	// The device powers up holding zero in every byte
	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;
	end

	// A byte is taken on the rising edge of the write strobe while the chip is selected
	// The sequencer keeps address and data stable across that edge
	always @(posedge we_n_i)
	begin
		if (!ce_n_i)
			mem[adr_i] = dat_i;
	end

	// ====================
	// Read path
	// ====================

	// Output follows the address with no delay, zero while not enabled
	assign dat_o = (!ce_n_i && !oe_n_i) ? mem[adr_i] : '0;

endmodule

/* tb/tb_mem12.sv */
// Testbench for mem12 with an SRAM model, a shadow memory reference and a self-checking report
`timescale 1ns/100ps

module tb_mem12;

	localparam int aw = mem_pkg::bus_adr_w;
	localparam int dw = mem_pkg::bus_dat_w;
	localparam int window = 4096;
	localparam int rand_ops = 200;
	// Directed tests use 11 transactions, the random test adds the rest
	localparam int txn_count = 11 + rand_ops;
	localparam int cycle_limit = 40 * txn_count + 200;

	logic                         wclk;
	logic                         rst;
	logic                         cyc;
	logic                         stb;
	logic                         we;
	logic [aw-1:0]                adr;
	logic [dw-1:0]                dat_w;
	logic [dw-1:0]                dat_r;
	logic                         ack;
	logic                         ram_ce_n;
	logic                         ram_we_n;
	logic                         ram_oe_n;
	logic [mem_pkg::ram_adr_w-1:0] ram_adr;
	logic [mem_pkg::ram_dat_w-1:0] ram_wdat;
	logic [mem_pkg::ram_dat_w-1:0] ram_rdat;

	// Shadow of every word in the test window and whether it was ever written
	logic [dw-1:0] shadow [0:window-1];
	logic          written [0:window-1];

	integer        seed = 16391;
	int            cycles = 0;
	int            test_errors = 0;
	int            error_count = 0;
	int            tests_passed = 0;
	int            tests_failed = 0;
	logic [31:0]   r_op;
	logic [31:0]   r_val;
	logic [aw-1:0] rand_adr;
	// Lowest value of the chip select seen during the last transaction
	logic          ce_min;
	// Address and data of the last finished read, handed to the compare process
	logic [aw-1:0] rd_adr;
	logic [dw-1:0] rd_dat;
	event          read_done;

	mem12_top #(
		.WR_PULSE   (2),
		.READ_STAGES(2)
	) u_dut (
		.wclk      (wclk),
		.rst       (rst),
		.cyc_i     (cyc),
		.stb_i     (stb),
		.we_i      (we),
		.adr_i     (adr),
		.dat_i     (dat_w),
		.dat_o     (dat_r),
		.ack_o     (ack),
		.ram_ce_n_o(ram_ce_n),
		.ram_we_n_o(ram_we_n),
		.ram_oe_n_o(ram_oe_n),
		.ram_adr_o (ram_adr),
		.ram_dat_o (ram_wdat),
		.ram_dat_i (ram_rdat)
	);

	sram_model u_sram (
		.ce_n_i(ram_ce_n),
		.we_n_i(ram_we_n),
		.oe_n_i(ram_oe_n),
		.adr_i (ram_adr),
		.dat_i (ram_wdat),
		.dat_o (ram_rdat)
	);

	// ====================
	// Clock and watchdog
	// ====================

	initial
		wclk = 1'b0;

	always #2 wclk = ~wclk;

	// A missing acknowledge stops the run here instead of hanging it
	always @(posedge wclk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, a transaction was never acknowledged", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ====================
	// Reference and checks
	// ====================

	// Last written word with both halves cut to six bits, zero for a word never written
	function automatic logic [dw-1:0] expected_word(input logic [aw-1:0] a);
		logic [dw-1:0] w;
		w = shadow[a[11:0]];
		if (!written[a[11:0]])
			return '0;
		else
			return {w[11:6] & 6'h3f, w[5:0] & 6'h3f};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("Error at %0d ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
			test_errors = test_errors + 1;
		end
	endtask

	// Every finished read is compared against the reference here
	always @(read_done)
	begin
		check_value("dat_o", 32'(expected_word(rd_adr)), 32'(rd_dat));
	end

	task automatic finish_test(input int num, input string name);
		if (test_errors == 0)
		begin
			$display("Test %0d %s: pass", num, name);
			tests_passed = tests_passed + 1;
		end
		else
		begin
			$display("Test %0d %s: fail with %0d mismatches", num, name, test_errors);
			tests_failed = tests_failed + 1;
		end
		error_count = error_count + test_errors;
		test_errors = 0;
	endtask

	// ====================
	// Bus master
	// ====================

	// Called 1 ns after a rising edge, returns at the same point of a later cycle
	task automatic bus_cycle(input logic write, input logic [aw-1:0] a, input logic [dw-1:0] d);
		logic ack_seen;
		ack_seen = 1'b0;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = a;
		dat_w = d;
		ce_min = 1'b1;
		while (!ack_seen)
		begin
			@(posedge wclk);
			#1;
			ce_min = ce_min & ram_ce_n;
			ack_seen = ack;
		end
		if (write)
		begin
			shadow[a[11:0]] = d;
			written[a[11:0]] = 1'b1;
		end
		else
		begin
			rd_adr = a;
			rd_dat = dat_r;
			-> read_done;
		end
		// Strobe stays low for one cycle and the acknowledge must follow it down
		cyc = 1'b0;
		stb = 1'b0;
		@(posedge wclk);
		#1;
		check_value("ack_o", 32'd0, 32'(ack));
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		rst = 1'b1;
		ce_min = 1'b1;
		rd_adr = '0;
		rd_dat = '0;
		for (int i = 0; i < window; i++)
		begin
			shadow[i] = '0;
			written[i] = 1'b0;
		end
		repeat (10) @(posedge wclk);
		#1;
		rst = 1'b0;
		@(posedge wclk);
		#1;

		// Idle state straight out of reset
		check_value("ram_ce_n_o", 32'd1, 32'(ram_ce_n));
		check_value("ram_we_n_o", 32'd1, 32'(ram_we_n));
		check_value("ram_oe_n_o", 32'd1, 32'(ram_oe_n));
		check_value("ack_o", 32'd0, 32'(ack));
		check_value("dat_o", 32'd0, 32'(dat_r));
		finish_test(1, "reset state");

		// The read misses and fills line 0x12 from SRAM
		bus_cycle(1'b1, 24'h000120, 12'ha5c);
		bus_cycle(1'b1, 24'h000121, 12'h3e7);
		bus_cycle(1'b0, 24'h000120, '0);
		check_value("ram_ce_n_o", 32'd0, 32'(ce_min));
		finish_test(2, "write then read");

		// Same line again, so the SRAM must stay deselected
		bus_cycle(1'b0, 24'h000121, '0);
		check_value("ram_ce_n_o", 32'd1, 32'(ce_min));
		finish_test(3, "read hit");

		// The write drops the cached line, so the read goes back to SRAM
		bus_cycle(1'b1, 24'h000120, 12'h71b);
		bus_cycle(1'b0, 24'h000120, '0);
		check_value("ram_ce_n_o", 32'd0, 32'(ce_min));
		finish_test(4, "write invalidate");

		// Address bit 11 differs, so both words compete for line 0x12
		bus_cycle(1'b1, 24'h000920, 12'h2c4);
		bus_cycle(1'b0, 24'h000120, '0);
		bus_cycle(1'b0, 24'h000920, '0);
		bus_cycle(1'b0, 24'h000120, '0);
		bus_cycle(1'b0, 24'h000920, '0);
		finish_test(5, "index conflict");

		// Writes dominate the mix because every read miss costs a whole line fill
		for (int i = 0; i < rand_ops; i++)
		begin
			r_op = $random(seed);
			r_val = $random(seed);
			rand_adr = {12'h000, r_op[11:0]};
			if (r_op[31:28] < 4'd3)
				bus_cycle(1'b0, rand_adr, '0);
			else
				bus_cycle(1'b1, rand_adr, r_val[11:0]);
		end
		finish_test(6, "random traffic");

		$display("%0d tests, %0d passed, %0d failed, %0d mismatches",
			tests_passed + tests_failed, tests_passed, tests_failed, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* mem12.f */
common/mem_pkg.sv
common/cache_pkg.sv
sram_seq/sram_sequencer.sv
read_cache/read_cache.sv
design/bus_ack_gen.sv
design/mem12_top.sv
tb/sram_model.sv
tb/tb_mem12.sv

/* Makefile */
# Verilator build and run for the mem12 testbench

SRCS := $(shell cat mem12.f)

.PHONY: all run clean

all: run

# The simulator is rebuilt only when a source or the file list changes
obj_dir/Vtb_mem12: mem12.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_mem12 -f mem12.f

# The run fails when the log holds the fail message or the binary exits with an error
run: obj_dir/Vtb_mem12
	obj_dir/Vtb_mem12 > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
